// ==== uartRx.f ====
src/uartClockPkg.sv
src/uartFramePkg.sv
src/baudTickGen.sv
src/rxLineFilter.sv
src/serialReceiver.sv
src/rxLinkMonitor.sv
src/uartReceiveTop.sv
verif/uartRxTb.sv

// ==== Bender.yml ====
package:
  name: uartRx

sources:
  - files:
      - src/uartClockPkg.sv
      - src/uartFramePkg.sv
      - src/baudTickGen.sv
      - src/rxLineFilter.sv
      - src/serialReceiver.sv
      - src/rxLinkMonitor.sv
      - src/uartReceiveTop.sv
  - target: test
    files:
      - verif/uartRxTb.sv

// ==== verif/uartRxTb.sv ====
`timescale 1ns/10ps

// testbench driving 8N1 frames into uartReceiveTop over serialIn
module uartRxTb import uartClockPkg::*, uartFramePkg::*; ();

	localparam int bitCycles = oversample * baud8Divisor; // clocks per bit on the wire
	localparam int totalFrames = 23;                      // 20 random plus bad, resync and spike frames
	localparam int cycleLimit = (totalFrames * 12 + 40) * bitCycles;
	localparam int kindGood = 0;   // dataReady rise after a good stop bit
	localparam int kindError = 1;  // errorFlag rise
	localparam int kindResync = 2; // dataReady rise when resync finishes

	logic CLOCK_50;
	logic reset;
	logic serialIn;
	logic [dataBits-1:0] rxData;
	logic dataReady;
	logic errorFlag;
	logic [rxStateWidth-1:0] rxState;
	rxErrorWord errorCapture;
	logic [frameCountWidth-1:0] frameCount;
	logic [errorCountWidth-1:0] errorCount;

	// expected events in arrival order
	int expKind[$];
	logic [dataBits-1:0] expByte[$];
	logic [frameCountWidth-1:0] expFrames[$];
	logic [errorCountWidth-1:0] expErrors[$];
	logic [frameCountWidth-1:0] modelFrames; // model's own counters
	logic [errorCountWidth-1:0] modelErrors;
	rxErrorWord expCapture;
	int failCount;
	int checksRun;
	int testsRun;
	int cycleCount = 0;
	integer seed;

	uartReceiveTop DUT (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.serialIn     (serialIn),
		.rxData       (rxData),
		.dataReady    (dataReady),
		.errorFlag    (errorFlag),
		.rxState      (rxState),
		.errorCapture (errorCapture),
		.frameCount   (frameCount),
		.errorCount   (errorCount)
	);

	always #50 CLOCK_50 = ~CLOCK_50; // 100 ns period

	// run limit
	always @(posedge CLOCK_50) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit) begin
			$display("timeout: run stopped after %0d cycles, %0d expected results never came",
				cycleCount, expKind.size());
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic checkFlag(input logic got, input logic expected, input string what);
		checksRun++;
		if (got !== expected) begin
			failCount++;
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic checkState(input logic [rxStateWidth-1:0] got,
			input logic [rxStateWidth-1:0] expected, input string what);
		checksRun++;
		if (got !== expected) begin
			failCount++;
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic checkByte(input logic [dataBits-1:0] got, input logic [dataBits-1:0] expected,
			input string what);
		checksRun++;
		if (got !== expected) begin
			failCount++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic checkCount(input logic [frameCountWidth-1:0] got,
			input logic [frameCountWidth-1:0] expected, input string what);
		checksRun++;
		if (got !== expected) begin
			failCount++;
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic checkErrors(input logic [errorCountWidth-1:0] got,
			input logic [errorCountWidth-1:0] expected, input string what);
		checksRun++;
		if (got !== expected) begin
			failCount++;
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic checkCapture(input rxErrorWord got, input rxErrorWord expected, input string what);
		checksRun++;
		if (got !== expected) begin
			failCount++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// lineBits holds start, data LSB first and stop in send order
	// result is {good, byte}
	function automatic logic [dataBits:0] expectFrame(input logic [dataBits+1:0] lineBits);
		logic good;
		logic [dataBits-1:0] value;
		for (int i = 0; i < dataBits; i++)
			value[i] = lineBits[i + 1];
		good = !lineBits[0] && lineBits[dataBits + 1]; // low start and high stop
		return {good, value};
	endfunction

	// holds one line level for a number of clocks starting 1 ns after the edge
	task automatic driveLine(input logic level, input int cycles);
		@(posedge CLOCK_50);
		#1 serialIn = level;
		repeat (cycles - 1) @(posedge CLOCK_50);
	endtask

	task automatic sendFrame(input logic [dataBits-1:0] value, input logic stopValue,
			input bit withSpike);
		logic [dataBits+1:0] lineBits;
		logic [dataBits:0] verdict;
		if (withSpike) begin
			driveLine(1'b0, baud8Divisor); // low for exactly one 8x tick
			driveLine(1'b1, 4 * bitCycles);
			// a false start would still be inside its frame here
			checkState(rxState, waitForStartBit, "rxState after spike");
			driveLine(1'b1, 8 * bitCycles); // a false frame would have completed by now
			checkCount(frameCount, modelFrames, "frameCount after spike");
			checkErrors(errorCount, modelErrors, "errorCount after spike");
		end
		lineBits = {stopValue, value, 1'b0};
		verdict = expectFrame(lineBits);
		if (verdict[dataBits]) begin
			modelFrames++;
			expKind.push_back(kindGood);
		end else begin
			modelErrors++;
			expKind.push_back(kindError);
		end
		expByte.push_back(verdict[dataBits-1:0]);
		expFrames.push_back(modelFrames);
		expErrors.push_back(modelErrors);
		for (int i = 0; i <= dataBits + 1; i++)
			driveLine(lineBits[i], bitCycles);
	endtask

	task automatic waitDrained();
		while (expKind.size() != 0)
			@(posedge CLOCK_50);
	endtask

	task automatic reportTest(input string name, input int failsBefore);
		testsRun++;
		if (failCount == failsBefore)
			$display("test %0d %s: ok", testsRun, name);
		else
			$display("test %0d %s: %0d mismatches", testsRun, name, failCount - failsBefore);
	endtask

	// compare on every rise of dataReady or errorFlag
	always begin
		@(posedge dataReady or posedge errorFlag);
		@(posedge CLOCK_50); // counters settle one cycle after the strobe
		#1;
		if (expKind.size() == 0) begin
			failCount++;
			$display("%0t: DUT reported a frame result that the model did not expect", $time);
		end else begin
			case (expKind[0])
				kindGood: begin
					checkFlag(dataReady, 1'b1, "dataReady");
					checkFlag(errorFlag, 1'b0, "errorFlag");
					checkByte(rxData, expByte[0], "rxData");
				end
				kindError: begin
					checkFlag(errorFlag, 1'b1, "errorFlag");
					checkFlag(dataReady, 1'b0, "dataReady");
					expCapture.frame.data = expByte[0];
					expCapture.frame.stop = 1'b0; // the failed stop sample
					checkCapture(errorCapture, expCapture, "errorCapture");
				end
				default: begin // resync done and the byte is lost
					checkFlag(dataReady, 1'b1, "dataReady after resync");
					checkFlag(errorFlag, 1'b0, "errorFlag after resync");
					checkState(rxState, waitForStartBit, "rxState after resync");
				end
			endcase
			checkCount(frameCount, expFrames[0], "frameCount");
			checkErrors(errorCount, expErrors[0], "errorCount");
			void'(expKind.pop_front());
			void'(expByte.pop_front());
			void'(expFrames.pop_front());
			void'(expErrors.pop_front());
		end
	end

	initial begin
		int failsBefore;
		logic [dataBits-1:0] value;
		CLOCK_50 = 1'b0;
		reset = 1'b1;
		serialIn = 1'b1; // idle line
		seed = 74;
		failCount = 0;
		checksRun = 0;
		testsRun = 0;
		modelFrames = '0;
		modelErrors = '0;
		repeat (3) @(posedge CLOCK_50);
		#1 reset = 1'b0;

		failsBefore = failCount;
		checkFlag(dataReady, 1'b0, "dataReady after reset");
		checkFlag(errorFlag, 1'b0, "errorFlag after reset");
		checkCount(frameCount, '0, "frameCount after reset");
		checkErrors(errorCount, '0, "errorCount after reset");
		checkState(rxState, waitForStartBit, "rxState after reset");
		reportTest("reset state", failsBefore);

		failsBefore = failCount;
		repeat (20) begin // back to back frames
			value = dataBits'($random(seed));
			sendFrame(value, 1'b1, 1'b0);
		end
		waitDrained();
		checkCount(frameCount, 20, "frameCount after random frames");
		reportTest("random frames", failsBefore);

		failsBefore = failCount;
		value = dataBits'($random(seed));
		sendFrame(value, 1'b0, 1'b0); // stop bit held low
		waitDrained();
		reportTest("stop bit error", failsBefore);

		failsBefore = failCount;
		expKind.push_back(kindResync); // idle line lets the resync window fill with ones
		expByte.push_back(value);
		expFrames.push_back(modelFrames);
		expErrors.push_back(modelErrors);
		driveLine(1'b1, 10 * bitCycles);
		waitDrained();
		sendFrame(dataBits'($random(seed)), 1'b1, 1'b0);
		waitDrained();
		reportTest("resync", failsBefore);

		failsBefore = failCount;
		sendFrame(dataBits'($random(seed)), 1'b1, 1'b1);
		waitDrained();
		reportTest("spike rejection", failsBefore);

		$display("%0d tests, %0d checks, %0d failed", testsRun, checksRun, failCount);
		if (failCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== src/uartReceiveTop.sv ====
`timescale 1ns/10ps

// UART receive subsystem, 115200 8N1 on CLOCK_50
module uartReceiveTop import uartFramePkg::*; (
	input  logic CLOCK_50,
	input  logic reset,
	input  logic serialIn,                     // raw RX pin
	output logic [dataBits-1:0] rxData,
	output logic dataReady,
	output logic errorFlag,
	output logic [rxStateWidth-1:0] rxState,
	output rxErrorWord errorCapture,
	output logic [frameCountWidth-1:0] frameCount,
	output logic [errorCountWidth-1:0] errorCount
);

	logic baud8Tick; // 8x bit rate strobe
	logic cleanBit;  // filtered line
	logic frameDone;
	logic stopError;

	baudTickGen baudGen (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.baud8Tick (baud8Tick)
	);

	rxLineFilter lineFilter (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.baud8Tick (baud8Tick),
		.serialIn  (serialIn),
		.cleanBit  (cleanBit)
	);

	serialReceiver receiver (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.baud8Tick    (baud8Tick),
		.cleanBit     (cleanBit),
		.rxData       (rxData),
		.dataReady    (dataReady),
		.errorFlag    (errorFlag),
		.rxState      (rxState),
		.errorCapture (errorCapture),
		.frameDone    (frameDone),
		.stopError    (stopError)
	);

	rxLinkMonitor linkMonitor (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.frameDone  (frameDone),
		.stopError  (stopError),
		.frameCount (frameCount),
		.errorCount (errorCount)
	);

endmodule

// ==== src/rxLinkMonitor.sv ====
`timescale 1ns/10ps

// link health counters fed by the receiver strobes
module rxLinkMonitor import uartFramePkg::*; (
	input  logic CLOCK_50,
	input  logic reset,
	input  logic frameDone, // one cycle per good frame
	input  logic stopError, // one cycle per bad stop bit
	output logic [frameCountWidth-1:0] frameCount,
	output logic [errorCountWidth-1:0] errorCount
);

	// good frames, wraps silently
	always_ff @(posedge CLOCK_50) begin
		if (reset)
			frameCount <= '0;
		else if (frameDone)
			frameCount <= frameCount + 1'b1;
	end

	// stop bit failures, wraps silently
	always_ff @(posedge CLOCK_50) begin
		if (reset)
			errorCount <= '0;
		else if (stopError)
			errorCount <= errorCount + 1'b1;
	end

endmodule

// ==== src/serialReceiver.sv ====
`timescale 1ns/10ps

// 8N1 receive state machine with stop bit check and resync after framing loss
module serialReceiver import uartFramePkg::*; (
	input  logic CLOCK_50,
	input  logic reset,
	input  logic baud8Tick,
	input  logic cleanBit,                 // filtered line from rxLineFilter
	output logic [dataBits-1:0] rxData,    // last assembled byte
	output logic dataReady,                // level, cleared by next start bit
	output logic errorFlag,                // level, set on bad stop bit
	output logic [rxStateWidth-1:0] rxState,
	output rxErrorWord errorCapture,       // frame view on error, history view in resync
	output logic frameDone,                // one cycle, good frame
	output logic stopError                 // one cycle, bad stop bit
);

	localparam int indexWidth = $clog2(dataBits);
	localparam logic [indexWidth-1:0] indexLast = indexWidth'(dataBits - 1);

	logic [3:0] bitTimer;  // low 3 bits count, bit 3 sticks after the first wrap
	logic [3:0] timerNext;
	logic sampleNow;       // tick that lands on a bit center
	logic startSeen;       // low line while idle
	logic [indexWidth-1:0] bitIndex;   // data bit being filled, LSB first
	logic [indexWidth-1:0] resyncCount; // samples taken in the current resync window
	logic [dataBits:0] historyNext;    // history with this sample shifted in
	logic resyncOk;

	// 0..7, carry into bit 3, then 9, 10 ... so first center 10 ticks in, then every 8
	assign timerNext = ({1'b0, bitTimer[2:0]} + 4'd1) | {bitTimer[3], 3'b000};
	assign sampleNow = baud8Tick && (timerNext == bitTimerLast) && (rxState != waitForStartBit);
	assign startSeen = baud8Tick && (rxState == waitForStartBit) && !cleanBit;

	assign historyNext = {errorCapture.history[dataBits-1:0], cleanBit};
	// all idle, or oldest sample low and newest high (start then stop seen in window)
	assign resyncOk = (&historyNext) || (!historyNext[dataBits] && historyNext[0]);

	// bit-center timer, parked at zero while idle
	always_ff @(posedge CLOCK_50) begin
		if (reset || rxState == waitForStartBit)
			bitTimer <= 4'd0;
		else if (baud8Tick)
			bitTimer <= timerNext;
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			rxState <= waitForStartBit;
			rxData <= '0;
			dataReady <= 1'b0;
			errorFlag <= 1'b0;
			bitIndex <= '0;
			resyncCount <= '0;
			frameDone <= 1'b0;
			stopError <= 1'b0;
		end else begin
			frameDone <= 1'b0; // strobes default low
			stopError <= 1'b0;

			if (startSeen) begin
				bitIndex <= '0;
				dataReady <= 1'b0; // consumer had until now to read rxData
				errorFlag <= 1'b0;
				rxState <= collectData;
			end

			if (sampleNow) begin
				case (rxState)
					collectData: begin
						rxData[bitIndex] <= cleanBit;
						bitIndex <= bitIndex + 1'b1;
						if (bitIndex == indexLast)
							rxState <= waitForStopBit;
					end

					waitForStopBit: begin
						if (cleanBit) begin // good stop bit
							dataReady <= 1'b1;
							frameDone <= 1'b1;
							rxState <= waitForStartBit;
						end else begin
							// framing lost, keep what we got for inspection
							errorFlag <= 1'b1;
							stopError <= 1'b1;
							errorCapture.frame.data <= rxData;
							errorCapture.frame.stop <= cleanBit;
							resyncCount <= '0;
							rxState <= resyncError;
						end
					end

					resyncError: begin
						errorCapture.history <= historyNext; // raw sample shift
						resyncCount <= resyncCount + 1'b1;   // wraps for the next window
						if (resyncCount == indexLast && resyncOk) begin
							// back in step, byte itself is lost
							errorFlag <= 1'b0;
							dataReady <= 1'b1;
							rxState <= waitForStartBit;
						end
					end

					default: rxState <= waitForStartBit; // unused codes fall back to idle
				endcase
			end
		end
	end

endmodule

// ==== src/rxLineFilter.sv ====
`timescale 1ns/10ps

// synchronizer and spike filter on the serial input, sampled at the 8x tick
module rxLineFilter (
	input  logic CLOCK_50,
	input  logic reset,
	input  logic baud8Tick,
	input  logic serialIn, // raw line, asynchronous
	output logic cleanBit  // filtered line, idle high
);

	logic [1:0] syncInv;   // inverted line, so idle reads 0 out of reset
	logic [1:0] voteCount; // saturating up/down vote, counts toward line low

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			syncInv <= 2'b00;
			voteCount <= 2'b00;
			cleanBit <= 1'b1; // no phantom start bit at power up
		end else if (baud8Tick) begin
			syncInv <= {syncInv[0], ~serialIn}; // two-stage sync

			// move the vote, hold at the ends
			if (syncInv[1] && voteCount != 2'b11)
				voteCount <= voteCount + 2'b01;
			else if (!syncInv[1] && voteCount != 2'b00)
				voteCount <= voteCount - 2'b01;

			// only flip at the extremes, a single tick blip never reaches them
			if (voteCount == 2'b00)
				cleanBit <= 1'b1;
			else if (voteCount == 2'b11)
				cleanBit <= 1'b0;
		end
	end

endmodule

// ==== src/baudTickGen.sv ====
`timescale 1ns/10ps

// one-cycle strobe at 8x the bit rate
module baudTickGen import uartClockPkg::*; (
	input  logic CLOCK_50,
	input  logic reset,
	output logic baud8Tick // high for one cycle every baud8Divisor cycles
);

	localparam logic [tickCountWidth-1:0] countLast = tickCountWidth'(baud8Divisor - 1);

	logic [tickCountWidth-1:0] tickCount; // modulo baud8Divisor

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			tickCount <= '0;
			baud8Tick <= 1'b0;
		end else if (tickCount == countLast) begin // wrap point
			tickCount <= '0;
			baud8Tick <= 1'b1;
		end else begin
			tickCount <= tickCount + 1'b1;
			baud8Tick <= 1'b0; // strobe lasts one cycle only
		end
	end

endmodule

// ==== src/uartFramePkg.sv ====
package uartFramePkg;

	// fixed 8N1 frame
	localparam int dataBits = 8;

	// link statistics widths
	localparam int frameCountWidth = 18; // good frames, wraps
	localparam int errorCountWidth = 7;  // stop bit failures, wraps

	// receiver state encoding
	localparam int rxStateWidth = 4;
	localparam logic [rxStateWidth-1:0] waitForStartBit = 4'd0; // idle, looking for a low
	localparam logic [rxStateWidth-1:0] collectData = 4'd1;     // shifting in data bits
	localparam logic [rxStateWidth-1:0] waitForStopBit = 4'd2;  // expecting a high
	localparam logic [rxStateWidth-1:0] resyncError = 4'd3;     // lost framing, hunting

	// timer value at a bit center: 8 ticks then carry, then +2 on the first bit
	localparam logic [3:0] bitTimerLast = 4'd10;

	// error capture word, two readings of the same 9 flops
	typedef union packed {
		struct packed {
			logic [dataBits-1:0] data; // byte assembled before the bad stop bit
			logic stop;                // the stop sample itself, always 0 here
		} frame;
		logic [dataBits:0] history;   // raw samples shifted in during resync
	} rxErrorWord;

endpackage

// ==== src/uartClockPkg.sv ====
package uartClockPkg;

	// board clock and line rate
	localparam logic [31:0] clockHz = 32'd50_000_000; // CLOCK_50
	localparam logic [31:0] baudRate = 32'd115_200;   // bits per second on the wire
	localparam int oversample = 8;                    // ticks per bit

	// 50e6 / (115200 * 8) = 54.25, rounded to nearest
	localparam int baud8Divisor =
		(clockHz + (baudRate * oversample) / 2) / (baudRate * oversample);

	// divisor counter must hold baud8Divisor - 1
	localparam int tickCountWidth = 6;

endpackage
